/* rtl/disp_defs.svh */
`ifndef DISP_DEFS_SVH
`define DISP_DEFS_SVH

////////////////////////////////////////////////////////////
// Display geometry
////////////////////////////////////////////////////////////

`define DISP_DIGITS 8        // Tubes on the board
`define DISP_VALUE_W 24      // Binary input width, up to 16777215

////////////////////////////////////////////////////////////
// Default divider ratios, 100 MHz system clock
////////////////////////////////////////////////////////////

// One scan step per ms, full refresh at 125 Hz
`define DISP_SCAN_DIV 100000
`define DISP_BLINK_DIV 16666666 // Blink phase length, about 3 Hz

`endif

/* rtl/disp_pkg.sv */
`include "disp_defs.svh"

package disp_pkg;

  ////////////////////////////////////////////////////////////
  // Digit codes
  ////////////////////////////////////////////////////////////

  // 0 to 9 are decimals, everything else shows dark
  typedef logic [3:0] digit_t;

  localparam digit_t DIGIT_BLANK = 4'hF; // All segments off

  // Digit 0 sits in bits 3:0, digit 7 in bits 31:28
  typedef digit_t [`DISP_DIGITS-1:0] digit_vec_t;

  ////////////////////////////////////////////////////////////
  // Tube side
  ////////////////////////////////////////////////////////////

  // Active high pattern
  // bit 7 = a, bit 6 = b ... bit 1 = g, bit 0 = dp
  typedef logic [7:0] seg_t;

  // One hot, bit 7 is the leftmost tube
  typedef logic [`DISP_DIGITS-1:0] digit_sel_t;

endpackage

/* rtl/tick_gen.sv */
`timescale 1ns/1ps

module tick_gen #(
  parameter int DIVIDE = 4 // Clocks per tick
) (
  input  logic clk,
  input  logic rst_n,
  input  logic enable,
  output logic tick
);

  // At least one bit even for DIVIDE of 1
  localparam int CNT_W = (DIVIDE > 1) ? $clog2(DIVIDE) : 1;

  logic [CNT_W-1:0] cnt;
  logic             wrap;

  assign wrap = (cnt == CNT_W'(DIVIDE - 1)); // Last count of the period

  // One cycle pulse, only while counting
  assign tick = enable & wrap;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (!enable) begin
      cnt <= '0;                            // Restart the period on re-enable
    end else if (wrap) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

/* rtl/bin_to_bcd.sv */
`timescale 1ns/1ps
`include "disp_defs.svh"

module bin_to_bcd (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     start,
  input  logic [`DISP_VALUE_W-1:0] value,
  output logic                     busy,
  output logic                     done,
  output disp_pkg::digit_vec_t     digits
);

  localparam int VW    = `DISP_VALUE_W;
  localparam int BCD_W = $bits(disp_pkg::digit_vec_t);
  localparam int CNT_W = $clog2(VW);

  logic [CNT_W-1:0]     bit_cnt;  // Shifts done so far
  logic [VW-1:0]        bin_sr;   // Binary bits still to shift in
  disp_pkg::digit_vec_t bcd;      // Digits under construction
  disp_pkg::digit_vec_t adj;      // Digits after the add-3 step
  logic [BCD_W+VW-1:0]  shift_next;

  ////////////////////////////////////////////////////////////
  // Add 3 to every nibble of 5 or more
  ////////////////////////////////////////////////////////////

  function automatic disp_pkg::digit_vec_t add3(input disp_pkg::digit_vec_t d);
    disp_pkg::digit_vec_t r;
    r = d;
    for (int i = 0; i < `DISP_DIGITS; i++) begin
      if (d[i] >= 4'd5) begin
        r[i] = d[i] + 4'd3; // Carries into the next digit on the shift
      end
    end
    return r;
  endfunction

  assign adj        = add3(bcd);
  assign shift_next = {adj, bin_sr} << 1; // MSB of binary enters digit 0
  assign digits     = bcd;                // Valid while done is high

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      done    <= 1'b0;
      bit_cnt <= '0;
    end else begin
      done <= 1'b0;                              // Strobe by default
      if (busy) begin
        bit_cnt <= bit_cnt + 1'b1;
        if (bit_cnt == CNT_W'(VW - 1)) begin
          busy <= 1'b0;
          done <= 1'b1;                          // Same edge as the last shift
        end
      end else if (start) begin
        busy    <= 1'b1;
        bit_cnt <= '0;
      end
    end
  end

  // Datapath, no reset
  always_ff @(posedge clk) begin
    if (busy) begin
      bcd    <= shift_next[BCD_W+VW-1:VW];
      bin_sr <= shift_next[VW-1:0];
    end else if (start) begin
      bcd    <= '0;                              // Leading zeros kept
      bin_sr <= value;
    end
  end

  // Load while converting is dropped
  a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
    start |-> !busy)
    else $error("bin_to_bcd start while busy");

  // Fixed latency seen by the arbiter and load_done
  a_done_latency: assert property (@(posedge clk) disable iff (!rst_n)
    (start && !busy) |-> ##25 done)
    else $error("bin_to_bcd done not 25 cycles after start");

endmodule

/* rtl/buffer_arbiter.sv */
`timescale 1ns/1ps
`include "disp_defs.svh"

module buffer_arbiter (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             bulk_req,     // From the converter
  input  disp_pkg::digit_vec_t             bulk_digits,
  input  logic                             raw_req,      // Direct digit write
  input  logic [$clog2(`DISP_DIGITS)-1:0]  raw_idx,
  input  disp_pkg::digit_t                 raw_val,
  output logic                             wr_all,
  output disp_pkg::digit_vec_t             all_digits,
  output logic                             wr_one,
  output logic [$clog2(`DISP_DIGITS)-1:0]  one_idx,
  output disp_pkg::digit_t                 one_val
);

  localparam int IDX_W = $clog2(`DISP_DIGITS);

  // One entry hold for a raw write that lost to the bulk write
  logic             hold_valid;
  logic [IDX_W-1:0] hold_idx;
  disp_pkg::digit_t hold_val;

  ////////////////////////////////////////////////////////////
  // Grant, bulk write first
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_all     <= 1'b0;
      wr_one     <= 1'b0;
      hold_valid <= 1'b0;
    end else begin
      wr_all <= bulk_req;
      if (bulk_req) begin
        wr_one <= 1'b0;                       // Raw side waits a cycle
        if (raw_req) begin
          hold_valid <= 1'b1;
        end
      end else begin
        wr_one     <= raw_req | hold_valid;   // Fresh raw write or the held one
        hold_valid <= 1'b0;
      end
    end
  end

  // Payload path
  always_ff @(posedge clk) begin
    all_digits <= bulk_digits;
    if (bulk_req && raw_req) begin
      hold_idx <= raw_idx;
      hold_val <= raw_val;
    end
    if (!bulk_req) begin
      if (raw_req) begin
        one_idx <= raw_idx;                   // Newer write replaces the held one
        one_val <= raw_val;
      end else if (hold_valid) begin
        one_idx <= hold_idx;
        one_val <= hold_val;
      end
    end
  end

  // Buffer takes one write per cycle
  a_wr_mutex: assert property (@(posedge clk) disable iff (!rst_n)
    !(wr_all && wr_one))
    else $error("buffer_arbiter bulk and single write together");

  // A held write is lost if another raw write comes in
  a_hold_overwrite: assert property (@(posedge clk) disable iff (!rst_n)
    hold_valid |-> !raw_req)
    else $error("buffer_arbiter held digit write replaced");

endmodule

/* rtl/digit_buffer.sv */
`timescale 1ns/1ps
`include "disp_defs.svh"

module digit_buffer (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            wr_all,      // Replace all digits
  input  disp_pkg::digit_vec_t            all_digits,
  input  logic                            wr_one,      // Replace one digit
  input  logic [$clog2(`DISP_DIGITS)-1:0] one_idx,
  input  disp_pkg::digit_t                one_val,
  output disp_pkg::digit_vec_t            digits
);

  ////////////////////////////////////////////////////////////
  // Digit store
  ////////////////////////////////////////////////////////////

  disp_pkg::digit_vec_t store;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      store <= {`DISP_DIGITS{disp_pkg::DIGIT_BLANK}}; // Dark tubes until first write
    end else if (wr_all) begin
      store <= all_digits;
    end else if (wr_one) begin
      store[one_idx] <= one_val;                      // Other digits untouched
    end
  end

  // Read port, straight to the scanner
  assign digits = store;

endmodule

/* rtl/scan_driver.sv */
`timescale 1ns/1ps
`include "disp_defs.svh"

module scan_driver (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     scan_tick,    // Advance to the next tube
  input  logic                     blink_tick,   // Toggle blink phase
  input  logic                     blink_enable,
  input  logic [`DISP_DIGITS-1:0]  blink_mask,   // Tubes that blink
  input  disp_pkg::digit_vec_t     digits,
  output disp_pkg::digit_sel_t     seg_en,       // Active low tube enables
  output disp_pkg::seg_t           seg_out       // Active low segments
);

  localparam int IDX_W = $clog2(`DISP_DIGITS);

  disp_pkg::digit_sel_t sel;        // One hot, bit 7 first
  logic                 step_q;     // Tick delayed to the output stage
  logic                 phase_on;   // Blink phase, 1 = lit
  logic [IDX_W-1:0]     sel_idx;
  disp_pkg::digit_t     cur_digit;
  disp_pkg::seg_t       pattern;
  logic                 blink_dark;

  ////////////////////////////////////////////////////////////
  // Select rotation and blink phase
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sel      <= disp_pkg::digit_sel_t'(1) << (`DISP_DIGITS - 1);
      step_q   <= 1'b0;
      phase_on <= 1'b1;
    end else begin
      step_q <= scan_tick;
      if (scan_tick) begin
        if (sel[0]) begin
          sel <= disp_pkg::digit_sel_t'(1) << (`DISP_DIGITS - 1); // Wrap to digit 7
        end else begin
          sel <= sel >> 1;
        end
      end
      if (!blink_enable) begin
        phase_on <= 1'b1;                 // Start lit when blinking resumes
      end else if (blink_tick) begin
        phase_on <= ~phase_on;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Digit pick and segment encode
  ////////////////////////////////////////////////////////////

  always_comb begin
    sel_idx = '0;
    for (int i = 0; i < `DISP_DIGITS; i++) begin
      if (sel[i]) begin
        sel_idx = IDX_W'(i);
      end
    end
  end

  assign cur_digit  = digits[sel_idx];
  assign blink_dark = blink_enable & ~phase_on & blink_mask[sel_idx];

  always_comb begin
    case (cur_digit)
      4'd0:    pattern = 8'hFC;  // abcdef
      4'd1:    pattern = 8'h60;  // bc
      4'd2:    pattern = 8'hDA;  // abdeg
      4'd3:    pattern = 8'hF2;  // abcdg
      4'd4:    pattern = 8'h66;  // bcfg
      4'd5:    pattern = 8'hB6;  // acdfg
      4'd6:    pattern = 8'hBE;  // acdefg
      4'd7:    pattern = 8'hE0;  // abc
      4'd8:    pattern = 8'hFE;  // all but dp
      4'd9:    pattern = 8'hF6;  // abcdfg
      default: pattern = 8'h00;  // Blank and unused codes
    endcase
    if (blink_dark) begin
      pattern = 8'h00;
    end
  end

  // Output stage, one cycle after the select moves
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      seg_en  <= '1;                      // All tubes off
      seg_out <= '1;
    end else if (step_q) begin
      seg_en  <= ~sel;
      seg_out <= ~pattern;
    end
  end

  // Never two tubes driven, never none
  a_sel_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot(sel))
    else $error("scan_driver select not one hot");

endmodule

/* rtl/display_top.sv */
`timescale 1ns/1ps
`include "disp_defs.svh"

module display_top #(
  parameter int SCAN_DIV  = `DISP_SCAN_DIV,   // Clocks per tube step
  parameter int BLINK_DIV = `DISP_BLINK_DIV   // Clocks per blink phase
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic [`DISP_VALUE_W-1:0]        value,
  input  logic                            value_load,   // Convert and show value
  input  logic                            digit_wr,     // Direct single digit write
  input  logic [$clog2(`DISP_DIGITS)-1:0] digit_idx,
  input  disp_pkg::digit_t                digit_val,
  input  logic                            blink_enable,
  input  logic [`DISP_DIGITS-1:0]         blink_mask,
  output disp_pkg::digit_sel_t            seg_en,
  output disp_pkg::seg_t                  seg_out,
  output logic                            load_done     // Bulk write committed
);

  ////////////////////////////////////////////////////////////
  // Internal wires
  ////////////////////////////////////////////////////////////

  logic                            scan_tick;
  logic                            blink_tick;
  logic                            conv_done;
  disp_pkg::digit_vec_t            conv_digits;
  logic                            wr_all;
  disp_pkg::digit_vec_t            all_digits;
  logic                            wr_one;
  logic [$clog2(`DISP_DIGITS)-1:0] one_idx;
  disp_pkg::digit_t                one_val;
  disp_pkg::digit_vec_t            buf_digits;

  assign load_done = wr_all;  // Buffer commits on this strobe

  // Dividers
  tick_gen #(.DIVIDE(SCAN_DIV)) u_scan_tick (
    .clk    (clk),
    .rst_n  (rst_n),
    .enable (1'b1),           // Always scanning
    .tick   (scan_tick)
  );

  tick_gen #(.DIVIDE(BLINK_DIV)) u_blink_tick (
    .clk    (clk),
    .rst_n  (rst_n),
    .enable (blink_enable),
    .tick   (blink_tick)
  );

  bin_to_bcd u_bin_to_bcd (
    .clk    (clk),
    .rst_n  (rst_n),
    .start  (value_load),
    .value  (value),
    .busy   (),               // Only watched by the converter assertion
    .done   (conv_done),
    .digits (conv_digits)
  );

  buffer_arbiter u_buffer_arbiter (
    .clk         (clk),
    .rst_n       (rst_n),
    .bulk_req    (conv_done),
    .bulk_digits (conv_digits),
    .raw_req     (digit_wr),
    .raw_idx     (digit_idx),
    .raw_val     (digit_val),
    .wr_all      (wr_all),
    .all_digits  (all_digits),
    .wr_one      (wr_one),
    .one_idx     (one_idx),
    .one_val     (one_val)
  );

  digit_buffer u_digit_buffer (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_all     (wr_all),
    .all_digits (all_digits),
    .wr_one     (wr_one),
    .one_idx    (one_idx),
    .one_val    (one_val),
    .digits     (buf_digits)
  );

  scan_driver u_scan_driver (
    .clk          (clk),
    .rst_n        (rst_n),
    .scan_tick    (scan_tick),
    .blink_tick   (blink_tick),
    .blink_enable (blink_enable),
    .blink_mask   (blink_mask),
    .digits       (buf_digits),
    .seg_en       (seg_en),
    .seg_out      (seg_out)
  );

endmodule

/* test/tb_display.sv */
`timescale 1ns/1ps
`include "disp_defs.svh"

module tb_display;

  localparam int CLK_PERIOD = 100;
  localparam int N          = `DISP_DIGITS;
  localparam int SCAN_LIMIT = 100;    // Cycles allowed for one captured scan
  localparam int LOAD_LIMIT = 30;     // Cycles from load strobe to load_done

  // Cycle budget per test summed for the watchdog
  localparam int RESET_CYC  = 50;
  localparam int VALUE_CYC  = 6 * 140;
  localparam int RAW_CYC    = 2 * 110;
  localparam int COLL_CYC   = 150;
  localparam int BLINK_CYC  = 10 * 110;
  localparam int MARGIN_CYC = 400;
  localparam int TOTAL_CYC  = RESET_CYC + VALUE_CYC + RAW_CYC + COLL_CYC
                            + BLINK_CYC + MARGIN_CYC;

  // Active high segment bits with a in the top bit
  localparam logic [7:0] SEG_A = 8'h80;
  localparam logic [7:0] SEG_B = 8'h40;
  localparam logic [7:0] SEG_C = 8'h20;
  localparam logic [7:0] SEG_D = 8'h10;
  localparam logic [7:0] SEG_E = 8'h08;
  localparam logic [7:0] SEG_F = 8'h04;
  localparam logic [7:0] SEG_G = 8'h02;

  logic                     clk;
  logic                     rst_n;
  logic [`DISP_VALUE_W-1:0] value;
  logic                     value_load;
  logic                     digit_wr;
  logic [$clog2(N)-1:0]     digit_idx;
  disp_pkg::digit_t         digit_val;
  logic                     blink_enable;
  logic [N-1:0]             blink_mask;
  disp_pkg::digit_sel_t     seg_en;
  disp_pkg::seg_t           seg_out;
  logic                     load_done;

  int          errors;
  int          tests_run;
  int          tests_failed;
  logic [31:0] lcg_state;
  int          exp_digit [N];     // Expected digit code per tube
  logic [7:0]  cap_seg [N];       // Captured seg_out per tube
  logic        cap_ok;            // Last capture saw a full scan

  display_top #(
    .SCAN_DIV  (4),
    .BLINK_DIV (64)
  ) u_display_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .value        (value),
    .value_load   (value_load),
    .digit_wr     (digit_wr),
    .digit_idx    (digit_idx),
    .digit_val    (digit_val),
    .blink_enable (blink_enable),
    .blink_mask   (blink_mask),
    .seg_en       (seg_en),
    .seg_out      (seg_out),
    .load_done    (load_done)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Reference model and helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [7:0] seg_ref(input int d);
    case (d)
      0:       return SEG_A | SEG_B | SEG_C | SEG_D | SEG_E | SEG_F;
      1:       return SEG_B | SEG_C;
      2:       return SEG_A | SEG_B | SEG_D | SEG_E | SEG_G;
      3:       return SEG_A | SEG_B | SEG_C | SEG_D | SEG_G;
      4:       return SEG_B | SEG_C | SEG_F | SEG_G;
      5:       return SEG_A | SEG_C | SEG_D | SEG_F | SEG_G;
      6:       return SEG_A | SEG_C | SEG_D | SEG_E | SEG_F | SEG_G;
      7:       return SEG_A | SEG_B | SEG_C;
      8:       return SEG_A | SEG_B | SEG_C | SEG_D | SEG_E | SEG_F | SEG_G;
      9:       return SEG_A | SEG_B | SEG_C | SEG_D | SEG_F | SEG_G;
      default: return 8'h00;   // Blank and unused codes dark
    endcase
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp,
                          input string msg);
    if (got !== exp) begin
      $display("error at %0t ns: %s, got %0h expected %0h", $time, msg, got, exp);
      errors++;
    end
  endtask

  // Decimal digits by division with leading zeros kept
  task automatic set_expected_value(input int v);
    int rest;
    rest = v;
    for (int i = 0; i < N; i++) begin
      exp_digit[i] = rest % 10;
      rest = rest / 10;
    end
  endtask

  task automatic finish_test(input string name, input int err0);
    tests_run++;
    if (errors == err0) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - err0);
    end
  endtask

  // Records one scan starting at a fresh step onto tube 7
  task automatic capture_scan();
    disp_pkg::digit_sel_t prev;
    int                   cycles;
    int                   got;
    int                   idx;
    int                   zeros;
    logic                 started;
    cap_ok  = 1'b0;
    started = 1'b0;
    got     = 0;
    cycles  = 0;
    @(negedge clk);
    prev = seg_en;
    while (got < N && cycles < SCAN_LIMIT) begin
      @(negedge clk);                    // Outputs settled mid cycle
      cycles++;
      if (seg_en != prev) begin
        if (!started && seg_en == 8'h7F) begin
          started = 1'b1;
        end
        if (started) begin
          zeros = 0;
          idx   = 0;
          for (int i = 0; i < N; i++) begin
            if (!seg_en[i]) begin
              zeros++;
              idx = i;
            end
          end
          if (zeros != 1) begin
            $display("scan capture: tube enables %b are not one hot low", seg_en);
            errors++;
          end else begin
            cap_seg[idx] = seg_out;
            got++;
          end
        end
        prev = seg_en;
      end
    end
    if (got < N) begin
      $display("scan capture: no full scan seen within %0d cycles", SCAN_LIMIT);
      errors++;
    end else begin
      cap_ok = 1'b1;
    end
  endtask

  task automatic check_scan(input string name);
    logic [7:0] lit;
    capture_scan();
    if (cap_ok) begin
      for (int i = 0; i < N; i++) begin
        lit = ~seg_ref(exp_digit[i]);    // Active low on the pins
        check_eq(cap_seg[i], lit, $sformatf("%s tube %0d", name, i));
      end
    end
  endtask

  task automatic load_value(input logic [`DISP_VALUE_W-1:0] v);
    int   cycles;
    logic seen;
    @(posedge clk);
    #1;
    value      = v;
    value_load = 1'b1;
    @(posedge clk);
    #1;
    value_load = 1'b0;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < LOAD_LIMIT) begin
      @(negedge clk);
      cycles++;
      seen = load_done;
    end
    if (!seen) begin
      $display("value load: load_done did not pulse within %0d cycles", LOAD_LIMIT);
      errors++;
    end else begin
      @(negedge clk);                    // Buffer committed on the edge between
      check_eq(load_done, 1'b0, "load_done pulse width");
      set_expected_value(v);
      check_scan($sformatf("value %0d", v));
    end
  endtask

  task automatic write_digit(input logic [$clog2(N)-1:0] idx,
                             input disp_pkg::digit_t val);
    @(posedge clk);
    #1;
    digit_wr  = 1'b1;
    digit_idx = idx;
    digit_val = val;
    @(posedge clk);
    #1;
    digit_wr = 1'b0;
    repeat (2) @(posedge clk);           // Arbiter stage then buffer write
    exp_digit[idx] = val;
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset();
    int err0;
    err0  = errors;
    rst_n = 1'b0;
    repeat (7) @(posedge clk);
    @(negedge clk);
    check_eq(seg_en, 8'hFF, "seg_en in reset");
    check_eq(seg_out, 8'hFF, "seg_out in reset");
    @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_eq(seg_en, 8'hFF, "seg_en after reset");
    for (int i = 0; i < 30; i++) begin
      check_eq(load_done, 1'b0, "load_done after reset");
      check_eq(seg_out, 8'hFF, "seg_out blank buffer");  // All tubes blank
      @(negedge clk);
    end
    for (int i = 0; i < N; i++) begin
      exp_digit[i] = disp_pkg::DIGIT_BLANK;
    end
    finish_test("reset", err0);
  endtask

  task automatic test_value();
    int          err0;
    logic [31:0] vals [6];
    err0    = errors;
    vals[0] = 0;
    vals[1] = 24'hFFFFFF;                // 16777215
    for (int i = 2; i < 6; i++) begin
      lcg_state = lcg_next(lcg_state);
      vals[i]   = lcg_state[31:8];       // Upper 24 bits
    end
    for (int i = 0; i < 6; i++) begin
      load_value(vals[i][`DISP_VALUE_W-1:0]);
    end
    finish_test("value", err0);
  endtask

  task automatic test_raw();
    int err0;
    err0 = errors;
    write_digit(3, 4'd7);
    check_scan("raw digit 7");
    write_digit(0, disp_pkg::DIGIT_BLANK);
    check_scan("raw blank");
    check_eq(cap_seg[0], 8'hFF, "blank tube dark");
    finish_test("raw", err0);
  endtask

  // Raw write lands on the converter done cycle and is held one cycle
  task automatic test_collision();
    int                       err0;
    logic [`DISP_VALUE_W-1:0] v;
    err0      = errors;
    lcg_state = lcg_next(lcg_state);
    v         = lcg_state[31:8];
    @(posedge clk);
    #1;
    value      = v;
    value_load = 1'b1;
    @(posedge clk);                      // Converter starts here
    #1;
    value_load = 1'b0;
    repeat (24) @(posedge clk);
    #1;
    digit_wr  = 1'b1;                    // Seen with done 25 cycles after start
    digit_idx = 3'd2;
    digit_val = 4'd4;
    @(posedge clk);
    #1;
    digit_wr = 1'b0;
    @(negedge clk);
    check_eq(load_done, 1'b1, "load_done with colliding write");
    repeat (3) @(posedge clk);
    set_expected_value(v);
    exp_digit[2] = 4;                    // Held digit applied after the bulk
    check_scan("collision");
    finish_test("collision", err0);
  endtask

  task automatic test_blink();
    int         err0;
    int         lit_seen [N];
    int         dark_seen [N];
    logic [7:0] lit;
    err0 = errors;
    for (int i = 0; i < N; i++) begin
      lit_seen[i]  = 0;
      dark_seen[i] = 0;
    end
    @(posedge clk);
    #1;
    blink_mask   = 8'b0100_0010;         // Tubes 6 and 1
    blink_enable = 1'b1;
    repeat (8) begin
      capture_scan();
      if (cap_ok) begin
        for (int i = 0; i < N; i++) begin
          lit = ~seg_ref(exp_digit[i]);
          if (blink_mask[i] && cap_seg[i] == 8'hFF) begin
            dark_seen[i]++;
          end else begin
            check_eq(cap_seg[i], lit, $sformatf("blink tube %0d", i));
            if (cap_seg[i] == lit) begin
              lit_seen[i]++;
            end
          end
        end
      end
    end
    for (int i = 0; i < N; i++) begin
      if (blink_mask[i]) begin
        check_eq(lit_seen[i] > 0, 1'b1, $sformatf("blink tube %0d lit phase", i));
        check_eq(dark_seen[i] > 0, 1'b1, $sformatf("blink tube %0d dark phase", i));
      end
    end
    @(posedge clk);
    #1;
    blink_enable = 1'b0;                 // Everything lit again
    repeat (2) check_scan("blink off");
    finish_test("blink", err0);
  endtask

  ////////////////////////////////////////////////////////////
  // Sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    rst_n        = 1'b0;
    value        = '0;
    value_load   = 1'b0;
    digit_wr     = 1'b0;
    digit_idx    = '0;
    digit_val    = '0;
    blink_enable = 1'b0;
    blink_mask   = '0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    lcg_state    = 32'h6e0b76ca;
    test_reset();
    test_value();
    test_raw();
    test_collision();
    test_blink();
    $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin
    #(TOTAL_CYC * CLK_PERIOD);
    $display("timeout: tests still running after %0d cycles", TOTAL_CYC);
    $display("TB FAILED");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+rtl
rtl/disp_pkg.sv
rtl/tick_gen.sv
rtl/bin_to_bcd.sv
rtl/buffer_arbiter.sv
rtl/digit_buffer.sv
rtl/scan_driver.sv
rtl/display_top.sv
test/tb_display.sv
